//--- Bender.yml
package:
  name: sound_block

sources:
  - src/sound_pkg.sv
  - src/rate_tick.sv
  - src/sb_dsp.sv
  - src/sb_mixer.sv
  - src/sample_mix.sv
  - src/sound_top.sv
  - target: simulation
    files:
      - verif/tb_sound.sv

//--- files.f
src/sound_pkg.sv
src/rate_tick.sv
src/sb_dsp.sv
src/sb_mixer.sv
src/sample_mix.sv
src/sound_top.sv
verif/tb_sound.sv

//--- src/rate_tick.sv
// clock_rate is the clk frequency in Hz, at least 1 MHz and below about 267 MHz; ticks jitter by one cycle
`timescale 1ns/1ns
`default_nettype none

module rate_tick (
	input  wire        clk,
	input  wire        rst_n,
	input  wire [27:0] clock_rate,
	output logic       ce_1us
);

	logic [27:0] rate_q;
	logic [27:0] acc;
	logic [27:0] acc_sum;

	always_ff @(posedge clk) begin
		rate_q <= clock_rate;
	end

	assign acc_sum = acc + sound_pkg::TICK_STEP;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc    <= '0;
			ce_1us <= 1'b0;
		end else if (acc_sum >= rate_q) begin
			acc    <= acc_sum - rate_q; // keep the fraction
			ce_1us <= 1'b1;
		end else begin
			acc    <= acc_sum;
			ce_1us <= 1'b0;
		end
	end

	// a rate under 1 MHz would need more than one tick per cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		rate_q >= sound_pkg::TICK_STEP)
		else $error("rate_tick: clock_rate below 1 MHz");

endmodule

`default_nettype wire

//--- src/sample_mix.sv
// signed 16-bit sources; each source is halved before the sum so the output cannot overflow
`timescale 1ns/1ns
`default_nettype none

module sample_mix (
	input  wire         clk,
	input  wire  [15:0] dsp_sample,
	input  wire  [15:0] fm_l,
	input  wire  [15:0] fm_r,
	input  wire  [4:0]  vol_voice_l,
	input  wire  [4:0]  vol_voice_r,
	input  wire  [4:0]  vol_fm_l,
	input  wire  [4:0]  vol_fm_r,
	output logic [15:0] sample_l,
	output logic [15:0] sample_r
);

	logic [15:0] voice_l_q;
	logic [15:0] voice_r_q;
	logic [15:0] fm_l_q;
	logic [15:0] fm_r_q;

	// 6 dB per volume step, top four bits only
	function automatic logic [15:0] attenuate(input logic [15:0] s, input logic [4:0] vol);
		logic [3:0] shift;
		shift = 4'd15 - vol[4:1];
		return $signed(s) >>> shift;
	endfunction

	function automatic logic [15:0] half(input logic [15:0] s);
		return {s[15], s[15:1]};
	endfunction

	// stage 1, attenuate
	always_ff @(posedge clk) begin
		voice_l_q <= attenuate(dsp_sample, vol_voice_l); // mono voice on both sides
		voice_r_q <= attenuate(dsp_sample, vol_voice_r);
		fm_l_q    <= attenuate(fm_l, vol_fm_l);
		fm_r_q    <= attenuate(fm_r, vol_fm_r);
	end

	// stage 2, sum
	always_ff @(posedge clk) begin
		sample_l <= half(voice_l_q) + half(fm_l_q);
		sample_r <= half(voice_r_q) + half(fm_r_q);
	end

endmodule

`default_nettype wire

//--- src/sb_dsp.sv
// minimal dsp: reset handshake, direct dac, speaker, ident and forced 8-bit irq only; no dma
`timescale 1ns/1ns
`default_nettype none

module sb_dsp (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         ce_1us,
	input  wire  [3:0]  address,
	input  wire         rd,
	input  wire         wr,
	input  wire  [7:0]  writedata,
	output logic [7:0]  rd_data,
	output logic        irq8,
	output logic [15:0] dsp_sample
);

	logic [2:0] state;
	logic [7:0] cmd;       // command awaiting its argument
	logic [3:0] reset_cnt;
	logic [7:0] out_byte;
	logic       out_valid;
	logic       speaker;
	logic       cmd_wr;

	assign cmd_wr = wr && (address == sound_pkg::PORT_DSP_WRITE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= sound_pkg::DSP_ST_IDLE;
			cmd        <= 8'h00;
			reset_cnt  <= 4'd0;
			out_byte   <= 8'h00;
			out_valid  <= 1'b0;
			speaker    <= 1'b0;
			irq8       <= 1'b0;
			dsp_sample <= 16'h0000;
		end else begin
			if (rd && address == sound_pkg::PORT_DSP_READ)
				out_valid <= 1'b0;
			if (rd && address == sound_pkg::PORT_DSP_STATUS)
				irq8 <= 1'b0; // status read acks the irq

			if (wr && address == sound_pkg::PORT_DSP_RESET) begin
				if (writedata[0]) begin
					state      <= sound_pkg::DSP_ST_HOLD;
					out_valid  <= 1'b0;
					speaker    <= 1'b0;
					irq8       <= 1'b0;
					dsp_sample <= 16'h0000;
				end else if (state == sound_pkg::DSP_ST_HOLD) begin
					state     <= sound_pkg::DSP_ST_COUNT;
					reset_cnt <= sound_pkg::DSP_RESET_US;
				end
			end else begin
				case (state)
					sound_pkg::DSP_ST_COUNT: begin
						if (ce_1us) begin
							if (reset_cnt == 4'd1) begin
								out_byte  <= sound_pkg::DSP_READY_BYTE;
								out_valid <= 1'b1;
								state     <= sound_pkg::DSP_ST_CMD;
							end else begin
								reset_cnt <= reset_cnt - 4'd1;
							end
						end
					end
					sound_pkg::DSP_ST_CMD: begin
						if (cmd_wr) begin
							cmd <= writedata;
							case (writedata)
								sound_pkg::DSP_CMD_DIRECT,
								sound_pkg::DSP_CMD_IDENT: state <= sound_pkg::DSP_ST_ARG;
								sound_pkg::DSP_CMD_SPK_ON: speaker <= 1'b1;
								sound_pkg::DSP_CMD_SPK_OFF: begin
									speaker    <= 1'b0;
									dsp_sample <= 16'h0000;
								end
								sound_pkg::DSP_CMD_IRQ8: irq8 <= 1'b1;
								default: ; // unknown commands dropped
							endcase
						end
					end
					sound_pkg::DSP_ST_ARG: begin
						if (cmd_wr) begin
							state <= sound_pkg::DSP_ST_CMD;
							if (cmd == sound_pkg::DSP_CMD_IDENT) begin
								out_byte  <= ~writedata;
								out_valid <= 1'b1;
							end else if (speaker) begin
								// unsigned 8-bit to signed, in the high byte
								dsp_sample <= {~writedata[7], writedata[6:0], 8'h00};
							end else begin
								dsp_sample <= 16'h0000;
							end
						end
					end
					default: ; // idle and hold wait on the reset port
				endcase
			end
		end
	end

	always_comb begin
		case (address)
			sound_pkg::PORT_DSP_READ:   rd_data = out_byte;
			sound_pkg::PORT_DSP_STATUS: rd_data = {out_valid, 7'h00};
			default:                    rd_data = 8'h00; // write port always ready
		endcase
	end

	// the top gates both strobes from one bus cycle
	assert property (@(posedge clk) disable iff (!rst_n) !(wr && rd))
		else $error("sb_dsp: read and write strobes together");

endmodule

`default_nettype wire

//--- src/sb_mixer.sv
// mixer registers for master, voice and fm only; cd, line and dma select registers read as 0
`timescale 1ns/1ns
`default_nettype none

module sb_mixer (
	input  wire        clk,
	input  wire        rst_n,
	input  wire  [3:0] address,
	input  wire        wr,
	input  wire  [7:0] writedata,
	input  wire        irq8,
	output logic [7:0] mix_rd_data,
	output logic [4:0] vol_master_l,
	output logic [4:0] vol_master_r,
	output logic [4:0] vol_voice_l,
	output logic [4:0] vol_voice_r,
	output logic [4:0] vol_fm_l,
	output logic [4:0] vol_fm_r,
	output logic [1:0] irq_sel
);

	logic [7:0]           mix_index;
	sound_pkg::vol_byte_u wr_vol;
	logic                 data_wr;

	// nibble to 5 bits, top bit repeated as lsb
	function automatic logic [4:0] widen(input logic [3:0] nib);
		return {nib, nib[3]};
	endfunction

	assign wr_vol  = writedata;
	assign data_wr = wr && (address == sound_pkg::PORT_MIX_DATA);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mix_index <= 8'h00;
		end else if (wr && address == sound_pkg::PORT_MIX_INDEX) begin
			mix_index <= writedata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || (data_wr && mix_index == sound_pkg::MIX_RESET)) begin
			vol_master_l <= sound_pkg::VOL_DEFAULT;
			vol_master_r <= sound_pkg::VOL_DEFAULT;
			vol_voice_l  <= sound_pkg::VOL_DEFAULT;
			vol_voice_r  <= sound_pkg::VOL_DEFAULT;
			vol_fm_l     <= sound_pkg::VOL_DEFAULT;
			vol_fm_r     <= sound_pkg::VOL_DEFAULT;
		end else if (data_wr) begin
			case (mix_index)
				sound_pkg::MIX_MASTER: begin
					vol_master_l <= widen(wr_vol.sbpro.left);
					vol_master_r <= widen(wr_vol.sbpro.right);
				end
				sound_pkg::MIX_VOICE: begin
					vol_voice_l <= widen(wr_vol.sbpro.left);
					vol_voice_r <= widen(wr_vol.sbpro.right);
				end
				sound_pkg::MIX_FM: begin
					vol_fm_l <= widen(wr_vol.sbpro.left);
					vol_fm_r <= widen(wr_vol.sbpro.right);
				end
				sound_pkg::MIX_MASTER_L: vol_master_l <= wr_vol.sb16.level;
				sound_pkg::MIX_MASTER_R: vol_master_r <= wr_vol.sb16.level;
				sound_pkg::MIX_VOICE_L:  vol_voice_l  <= wr_vol.sb16.level;
				sound_pkg::MIX_VOICE_R:  vol_voice_r  <= wr_vol.sb16.level;
				sound_pkg::MIX_FM_L:     vol_fm_l     <= wr_vol.sb16.level;
				sound_pkg::MIX_FM_R:     vol_fm_r     <= wr_vol.sb16.level;
				default: ;
			endcase
		end
	end

	// irq line select, not touched by MIX_RESET
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_sel <= 2'b00;
		end else if (data_wr && mix_index == sound_pkg::MIX_IRQ_SEL) begin
			case (writedata[3:2])
				2'b01:   irq_sel <= 2'b01; // irq7
				2'b10:   irq_sel <= 2'b10; // irq10
				default: irq_sel <= 2'b00; // irq5
			endcase
		end
	end

	always_comb begin
		case (mix_index)
			sound_pkg::MIX_MASTER:   mix_rd_data = {vol_master_l[4:1], vol_master_r[4:1]};
			sound_pkg::MIX_VOICE:    mix_rd_data = {vol_voice_l[4:1], vol_voice_r[4:1]};
			sound_pkg::MIX_FM:       mix_rd_data = {vol_fm_l[4:1], vol_fm_r[4:1]};
			sound_pkg::MIX_MASTER_L: mix_rd_data = {vol_master_l, 3'b000};
			sound_pkg::MIX_MASTER_R: mix_rd_data = {vol_master_r, 3'b000};
			sound_pkg::MIX_VOICE_L:  mix_rd_data = {vol_voice_l, 3'b000};
			sound_pkg::MIX_VOICE_R:  mix_rd_data = {vol_voice_r, 3'b000};
			sound_pkg::MIX_FM_L:     mix_rd_data = {vol_fm_l, 3'b000};
			sound_pkg::MIX_FM_R:     mix_rd_data = {vol_fm_r, 3'b000};
			sound_pkg::MIX_IRQ_SEL:
				mix_rd_data = {4'h0, irq_sel[1], irq_sel[0], ~|irq_sel, 1'b0};
			sound_pkg::MIX_IRQ_STAT: mix_rd_data = {7'h00, irq8};
			default:                 mix_rd_data = 8'h00;
		endcase
	end

	// the top routes to exactly one irq line
	assert property (@(posedge clk) disable iff (!rst_n) irq_sel != 2'b11)
		else $error("sb_mixer: two irq lines selected");

endmodule

`default_nettype wire

//--- src/sound_pkg.sv
// constants and the mixer byte union shared by the audio block; port offsets are relative to the 16-port window
`default_nettype none

package sound_pkg;

	// port offsets inside the sb_cs window
	localparam logic [3:0] PORT_MIX_INDEX  = 4'h4;
	localparam logic [3:0] PORT_MIX_DATA   = 4'h5;
	localparam logic [3:0] PORT_DSP_RESET  = 4'h6;
	localparam logic [3:0] PORT_DSP_READ   = 4'hA;
	localparam logic [3:0] PORT_DSP_WRITE  = 4'hC;
	localparam logic [3:0] PORT_DSP_STATUS = 4'hE;

	// mixer register indices
	localparam logic [7:0] MIX_RESET    = 8'h00;
	localparam logic [7:0] MIX_VOICE    = 8'h04; // sbpro packed
	localparam logic [7:0] MIX_MASTER   = 8'h22; // sbpro packed
	localparam logic [7:0] MIX_FM       = 8'h26; // sbpro packed
	localparam logic [7:0] MIX_MASTER_L = 8'h30;
	localparam logic [7:0] MIX_MASTER_R = 8'h31;
	localparam logic [7:0] MIX_VOICE_L  = 8'h32;
	localparam logic [7:0] MIX_VOICE_R  = 8'h33;
	localparam logic [7:0] MIX_FM_L     = 8'h34;
	localparam logic [7:0] MIX_FM_R     = 8'h35;
	localparam logic [7:0] MIX_IRQ_SEL  = 8'h80;
	localparam logic [7:0] MIX_IRQ_STAT = 8'h82;

	// dsp command codes
	localparam logic [7:0] DSP_CMD_DIRECT  = 8'h10;
	localparam logic [7:0] DSP_CMD_SPK_ON  = 8'hD1;
	localparam logic [7:0] DSP_CMD_SPK_OFF = 8'hD3;
	localparam logic [7:0] DSP_CMD_IDENT   = 8'hE0;
	localparam logic [7:0] DSP_CMD_IRQ8    = 8'hF2;

	localparam logic [7:0] DSP_READY_BYTE = 8'hAA;
	localparam logic [3:0] DSP_RESET_US   = 4'd4; // ticks from reset release to ready

	// dsp state encoding
	localparam logic [2:0] DSP_ST_IDLE  = 3'd0; // no reset seen yet
	localparam logic [2:0] DSP_ST_HOLD  = 3'd1;
	localparam logic [2:0] DSP_ST_COUNT = 3'd2;
	localparam logic [2:0] DSP_ST_CMD   = 3'd3;
	localparam logic [2:0] DSP_ST_ARG   = 3'd4;

	localparam logic [27:0] TICK_STEP = 28'd1_000_000; // 1 MHz tick rate

	localparam logic [4:0] VOL_DEFAULT = 5'h1F;

	// sbpro view: two nibbles, left high
	typedef struct packed {
		logic [3:0] left;
		logic [3:0] right;
	} sbpro_vol_t;

	// sb16 view: one 5-bit level, low bits ignored
	typedef struct packed {
		logic [4:0] level;
		logic [2:0] pad;
	} sb16_vol_t;

	typedef union packed {
		sbpro_vol_t sbpro;
		sb16_vol_t  sb16;
	} vol_byte_u;

endpackage

`default_nettype wire

//--- src/sound_top.sv
// sound blaster style block without opl3, c/ms or dma; fm samples come in on fm_l and fm_r
`timescale 1ns/1ns
`default_nettype none

module sound_top (
	input  wire         clk,
	input  wire         rst_n,
	input  wire  [3:0]  address,
	input  wire         read,
	input  wire         write,
	input  wire  [7:0]  writedata,
	output logic [7:0]  readdata,
	input  wire         sb_cs,      // 16-port window
	input  wire  [27:0] clock_rate, // clk frequency in Hz
	input  wire  [15:0] fm_l,
	input  wire  [15:0] fm_r,
	output logic        irq_5,
	output logic        irq_7,
	output logic        irq_10,
	output logic [4:0]  vol_l,
	output logic [4:0]  vol_r,
	output logic [15:0] sample_l,
	output logic [15:0] sample_r
);

	logic        sb_read;
	logic        sb_write;
	logic        ce_1us;
	logic [7:0]  mix_rd_data;
	logic [7:0]  dsp_rd_data;
	logic        irq8;
	logic [15:0] dsp_sample;
	logic [4:0]  vol_voice_l;
	logic [4:0]  vol_voice_r;
	logic [4:0]  vol_fm_l;
	logic [4:0]  vol_fm_r;
	logic [1:0]  irq_sel;

	assign sb_read  = read & sb_cs;
	assign sb_write = write & sb_cs;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			readdata <= 8'h00;
		end else if (sb_read) begin
			readdata <= (address == sound_pkg::PORT_MIX_DATA) ? mix_rd_data : dsp_rd_data;
		end
	end

	assign irq_5  = irq8 & ~irq_sel[0] & ~irq_sel[1]; // default line
	assign irq_7  = irq8 & irq_sel[0];
	assign irq_10 = irq8 & irq_sel[1];

	rate_tick u_rate_tick (
		.clk        (clk),
		.rst_n      (rst_n),
		.clock_rate (clock_rate),
		.ce_1us     (ce_1us)
	);

	sb_dsp u_dsp (
		.clk        (clk),
		.rst_n      (rst_n),
		.ce_1us     (ce_1us),
		.address    (address),
		.rd         (sb_read),
		.wr         (sb_write),
		.writedata  (writedata),
		.rd_data    (dsp_rd_data),
		.irq8       (irq8),
		.dsp_sample (dsp_sample)
	);

	sb_mixer u_mixer (
		.clk          (clk),
		.rst_n        (rst_n),
		.address      (address),
		.wr           (sb_write),
		.writedata    (writedata),
		.irq8         (irq8),
		.mix_rd_data  (mix_rd_data),
		.vol_master_l (vol_l),
		.vol_master_r (vol_r),
		.vol_voice_l  (vol_voice_l),
		.vol_voice_r  (vol_voice_r),
		.vol_fm_l     (vol_fm_l),
		.vol_fm_r     (vol_fm_r),
		.irq_sel      (irq_sel)
	);

	sample_mix u_sample_mix (
		.clk         (clk),
		.dsp_sample  (dsp_sample),
		.fm_l        (fm_l),
		.fm_r        (fm_r),
		.vol_voice_l (vol_voice_l),
		.vol_voice_r (vol_voice_r),
		.vol_fm_l    (vol_fm_l),
		.vol_fm_r    (vol_fm_r),
		.sample_l    (sample_l),
		.sample_r    (sample_r)
	);

endmodule

`default_nettype wire

//--- verif/tb_sound.sv
// directed tests at clock_rate 4 MHz where ce_1us pulses every 4 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_sound;

	localparam int CYCLE_LIMIT = 2000; // well above the longest run, all 100 status polls included

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic [3:0]  address = 4'h0;
	logic        read = 1'b0;
	logic        write = 1'b0;
	logic [7:0]  writedata = 8'h00;
	logic        sb_cs = 1'b0;
	logic [27:0] clock_rate = 28'd4_000_000;
	logic [15:0] fm_l = 16'h0000;
	logic [15:0] fm_r = 16'h0000;
	logic [7:0]  readdata;
	logic        irq_5;
	logic        irq_7;
	logic        irq_10;
	logic [4:0]  vol_l;
	logic [4:0]  vol_r;
	logic [15:0] sample_l;
	logic [15:0] sample_r;

	int          errors = 0;
	int          errors_at_start = 0;
	int          tests_run = 0;
	int          cycles = 0;
	string       test_name = "";
	logic [31:0] rng = 32'd75;

	sound_top u_dut (
		.clk(clk), .rst_n(rst_n), .address(address), .read(read), .write(write),
		.writedata(writedata), .readdata(readdata), .sb_cs(sb_cs),
		.clock_rate(clock_rate), .fm_l(fm_l), .fm_r(fm_r),
		.irq_5(irq_5), .irq_7(irq_7), .irq_10(irq_10),
		.vol_l(vol_l), .vol_r(vol_r), .sample_l(sample_l), .sample_r(sample_r)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// sbpro nibble to 5-bit level, msb copied into the new lsb
	function automatic logic [4:0] nibble_to_level(input logic [3:0] nib);
		return nib * 2 + nib[3];
	endfunction

	// attenuate by 15 minus the top four volume bits, halve, then add
	function automatic logic [15:0] expect_mix(input logic [15:0] voice, input logic [15:0] fm,
			input logic [4:0] vv, input logic [4:0] vf);
		int v;
		int f;
		v = $signed(voice);
		f = $signed(fm);
		v = v >>> (15 - vv[4:1]);
		f = f >>> (15 - vf[4:1]);
		return 16'((v >>> 1) + (f >>> 1));
	endfunction

	task automatic io_write(input logic [3:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1 address = addr;
		writedata = data;
		write = 1'b1;
		sb_cs = 1'b1;
		@(posedge clk);
		#1 write = 1'b0;
		sb_cs = 1'b0;
	endtask

	task automatic io_read(input logic [3:0] addr, output logic [7:0] data);
		@(posedge clk);
		#1 address = addr;
		read = 1'b1;
		sb_cs = 1'b1;
		@(posedge clk);
		#1 read = 1'b0;
		sb_cs = 1'b0;
		data = readdata; // registered on the edge just passed
	endtask

	task automatic mix_write(input logic [7:0] idx, input logic [7:0] data);
		io_write(sound_pkg::PORT_MIX_INDEX, idx);
		io_write(sound_pkg::PORT_MIX_DATA, data);
	endtask

	task automatic mix_read(input logic [7:0] idx, output logic [7:0] data);
		io_write(sound_pkg::PORT_MIX_INDEX, idx);
		io_read(sound_pkg::PORT_MIX_DATA, data);
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_sample(input string what, input logic [15:0] exp,
			input logic [15:0] act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %0d, actual %0d", test_name, what,
				$signed(exp), $signed(act));
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == errors_at_start)
			$display("%s: ok", test_name);
		else
			$display("%s: %0d errors", test_name, errors - errors_at_start);
	endtask

	task automatic test_reset_defaults();
		logic [7:0] d;
		begin_test("reset_defaults");
		for (int i = 0; i < 6; i++) begin
			mix_read(sound_pkg::MIX_MASTER_L + i, d); // 30..35 per-channel
			check_byte($sformatf("level %h", sound_pkg::MIX_MASTER_L + i), 8'hF8, d);
		end
		mix_read(sound_pkg::MIX_IRQ_SEL, d);
		check_byte("irq select", 8'h02, d);
		check_byte("irq lines", 8'h00, {5'b0, irq_10, irq_7, irq_5});
		check_byte("vol_l", 8'h1F, {3'b0, vol_l});
		check_byte("vol_r", 8'h1F, {3'b0, vol_r});
		end_test();
	endtask

	task automatic test_dsp_reset();
		logic [7:0] d;
		int         polls;
		begin_test("dsp_reset");
		io_write(sound_pkg::PORT_DSP_RESET, 8'h01);
		io_write(sound_pkg::PORT_DSP_RESET, 8'h00);
		polls = 0;
		d = 8'h00;
		while (!d[7] && polls < 100) begin
			io_read(sound_pkg::PORT_DSP_STATUS, d);
			polls++;
		end
		if (!d[7]) begin
			$display("%s: dsp never reported ready after 100 status reads", test_name);
			errors++;
		end
		io_read(sound_pkg::PORT_DSP_READ, d);
		check_byte("ready byte", 8'hAA, d);
		end_test();
	endtask

	task automatic test_mixer_decode();
		logic [7:0] d;
		begin_test("mixer_decode");
		mix_write(sound_pkg::MIX_FM, 8'hA5);
		mix_read(sound_pkg::MIX_FM_L, d);
		check_byte("fm_l level", {nibble_to_level(4'hA), 3'b000}, d);
		mix_read(sound_pkg::MIX_FM_R, d);
		check_byte("fm_r level", {nibble_to_level(4'h5), 3'b000}, d);
		mix_write(sound_pkg::MIX_MASTER_L, 8'h68); // level 0d
		check_byte("vol_l", 8'h0D, {3'b0, vol_l});
		check_byte("vol_r untouched", 8'h1F, {3'b0, vol_r});
		mix_write(sound_pkg::MIX_RESET, 8'h00);
		check_byte("vol_l restored", 8'h1F, {3'b0, vol_l});
		mix_read(sound_pkg::MIX_FM_L, d);
		check_byte("fm_l restored", 8'hF8, d);
		end_test();
	endtask

	task automatic test_direct_dac();
		logic [7:0]  b;
		logic [15:0] voice;
		logic [4:0]  fm_lvl_l;
		logic [4:0]  fm_lvl_r;
		begin_test("direct_dac");
		fm_lvl_l = nibble_to_level(4'h7);
		fm_lvl_r = nibble_to_level(4'hC);
		mix_write(sound_pkg::MIX_VOICE_L, 8'hC0); // voice left at level 18
		mix_write(sound_pkg::MIX_FM, 8'h7C);
		io_write(sound_pkg::PORT_DSP_WRITE, sound_pkg::DSP_CMD_SPK_ON);
		for (int pass = 0; pass < 6; pass++) begin
			if (pass == 4)
				io_write(sound_pkg::PORT_DSP_WRITE, sound_pkg::DSP_CMD_SPK_OFF);
			rng = xorshift(rng);
			b = rng[7:0];
			voice = (pass < 4) ? {b ^ 8'h80, 8'h00} : 16'h0000; // silent with speaker off
			io_write(sound_pkg::PORT_DSP_WRITE, sound_pkg::DSP_CMD_DIRECT);
			io_write(sound_pkg::PORT_DSP_WRITE, b);
			fm_l = rng[31:16];
			fm_r = rng[23:8];
			repeat (2) @(posedge clk);
			#1 check_sample("sample_l", expect_mix(voice, fm_l, 5'h18, fm_lvl_l), sample_l);
			check_sample("sample_r", expect_mix(voice, fm_r, 5'h1F, fm_lvl_r), sample_r);
		end
		end_test();
	endtask

	task automatic test_irq_routing();
		logic [7:0] d;
		begin_test("irq_routing");
		io_write(sound_pkg::PORT_DSP_WRITE, sound_pkg::DSP_CMD_IRQ8);
		check_byte("irq5 raised", 8'h01, {5'b0, irq_10, irq_7, irq_5});
		mix_read(sound_pkg::MIX_IRQ_STAT, d);
		check_byte("irq status", 8'h01, d);
		mix_write(sound_pkg::MIX_IRQ_SEL, 8'h04);
		check_byte("irq7 routed", 8'h02, {5'b0, irq_10, irq_7, irq_5});
		mix_write(sound_pkg::MIX_IRQ_SEL, 8'h08);
		check_byte("irq10 routed", 8'h04, {5'b0, irq_10, irq_7, irq_5});
		io_read(sound_pkg::PORT_DSP_STATUS, d); // acks irq8
		check_byte("irq cleared", 8'h00, {5'b0, irq_10, irq_7, irq_5});
		mix_write(sound_pkg::MIX_IRQ_SEL, 8'h00);
		end_test();
	endtask

	task automatic test_ident();
		logic [7:0] b;
		logic [7:0] d;
		begin_test("ident");
		rng = xorshift(rng);
		b = rng[15:8];
		io_write(sound_pkg::PORT_DSP_WRITE, sound_pkg::DSP_CMD_IDENT);
		io_write(sound_pkg::PORT_DSP_WRITE, b);
		io_read(sound_pkg::PORT_DSP_READ, d);
		check_byte("inverted arg", ~b, d);
		end_test();
	endtask

	initial begin
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		test_reset_defaults();
		test_dsp_reset();
		test_mixer_decode();
		test_direct_dac();
		test_irq_routing();
		test_ident();
		$display("tests %0d, errors %0d, cycles %0d", tests_run, errors, cycles);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
